// ==== csr_alu.sv ====
`timescale 1ns/100ps

module csr_alu import csr_reg_pkg::*, csr_cmd_pkg::*; (
    input  csr_op_e    op,
    input  xlen_t      old_value,
    input  xlen_t      src,
    input  logic [4:0] zimm,
    output xlen_t      new_value
);

    xlen_t operand;

    assign operand = op[2] ? {59'b0, zimm} : src;

    always_comb begin
        if (op[3]) begin
            new_value = old_value;  // ecall and mret do not modify the CSR
        end else begin
            case (op[1:0])
                2'b01:   new_value = operand;
                2'b10:   new_value = old_value | operand;
                2'b11:   new_value = old_value & ~operand;
                default: new_value = old_value;
            endcase
        end
    end

endmodule

// ==== csr_cmd_pkg.sv ====
package csr_cmd_pkg;

    // bit 3 marks a non-CSR op, bit 2 picks the immediate source,
    // bits 1:0 pick write, set or clear
    typedef enum logic [3:0] {
        OP_CSRRW  = 4'b0001,
        OP_CSRRS  = 4'b0010,
        OP_CSRRC  = 4'b0011,
        OP_CSRRWI = 4'b0101,
        OP_CSRRSI = 4'b0110,
        OP_CSRRCI = 4'b0111,
        OP_ECALL  = 4'b1000,
        OP_MRET   = 4'b1001
    } csr_op_e;

    typedef enum logic [1:0] {
        RSP_DONE = 2'd0,            // CSR access completed, data holds the old value
        RSP_TRAP = 2'd1,            // ecall or illegal access, redirect to mtvec
        RSP_RET  = 2'd2,            // mret, redirect to mepc
        RSP_IRQ  = 2'd3             // timer interrupt taken between commands
    } rsp_kind_e;

endpackage

// ==== csr_cmd_queue.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_cmd_queue import csr_reg_pkg::*, csr_cmd_pkg::*; #(
    parameter int DEPTH = `CMD_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  csr_op_e   cmd_op,
    input  csr_addr_t cmd_addr,
    input  xlen_t     cmd_src,
    input  logic [4:0] cmd_zimm,
    input  xlen_t     cmd_pc,
    input  logic      head_pop,
    output logic      head_valid,
    output csr_op_e   head_op,
    output csr_addr_t head_addr,
    output xlen_t     head_src,
    output logic [4:0] head_zimm,
    output xlen_t     head_pc,
    output logic      cmd_credit
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    csr_op_e    op_mem   [DEPTH];
    csr_addr_t  addr_mem [DEPTH];
    xlen_t      src_mem  [DEPTH];
    logic [4:0] zimm_mem [DEPTH];
    xlen_t      pc_mem   [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign head_valid = (count != '0);
    assign head_op    = op_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_src   = src_mem[rd_ptr];
    assign head_zimm  = zimm_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (cmd_valid) begin        // sender credits keep this from hitting a full queue
            op_mem[wr_ptr]   <= cmd_op;
            addr_mem[wr_ptr] <= cmd_addr;
            src_mem[wr_ptr]  <= cmd_src;
            zimm_mem[wr_ptr] <= cmd_zimm;
            pc_mem[wr_ptr]   <= cmd_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (head_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count      <= count + CW'(cmd_valid) - CW'(head_pop);
            cmd_credit <= head_pop;  // one credit back per freed entry
        end
    end

endmodule

// ==== csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// machine-mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// MPP at machine mode with MPIE and MIE clear
`define MSTATUS_RESET 64'ha0001800

`define CAUSE_ILLEGAL 64'd2
`define CAUSE_ECALL_M 64'd11
`define CAUSE_MTI     {1'b1, 63'd7}

`define IRQ_MTI_BIT   7             // MTIP in mip and MTIE in mie share this bit

`define CMD_DEPTH     4             // queue entries and the sender's starting credits
`define RSP_CREDITS   2             // responses that may be outstanding at the receiver

`endif

// ==== csr_file.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_file import csr_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  csr_addr_t rd_addr,
    output xlen_t     rd_data,
    output logic      rd_err,
    input  logic      wr_en,
    input  csr_addr_t wr_addr,
    input  xlen_t     wr_data,
    input  logic      trap_en,
    input  xlen_t     trap_cause,
    input  xlen_t     trap_pc,
    input  xlen_t     trap_tval,
    input  logic      ret_en,
    input  logic      irq_timer,
    output xlen_t     mtvec,
    output xlen_t     mepc,
    output logic      irq_pending
);

    mstatus_t mstatus;
    xlen_t    mie;
    xlen_t    mscratch;
    xlen_t    mcause;
    xlen_t    mtval;
    logic     mtip;                 // the only implemented bit of mip
    xlen_t    mip;

    always_comb begin
        mip = '0;
        mip[`IRQ_MTI_BIT] = mtip;
    end

    always_comb begin
        rd_err = 1'b0;
        case (rd_addr)
            `CSR_MSTATUS:  rd_data = mstatus.raw;
            `CSR_MIE:      rd_data = mie;
            `CSR_MTVEC:    rd_data = mtvec;
            `CSR_MSCRATCH: rd_data = mscratch;
            `CSR_MEPC:     rd_data = mepc;
            `CSR_MCAUSE:   rd_data = mcause;
            `CSR_MTVAL:    rd_data = mtval;
            `CSR_MIP:      rd_data = mip;
            default: begin
                rd_data = '0;
                rd_err  = 1'b1;
            end
        endcase
    end

    assign irq_pending = mstatus.f.mie & mie[`IRQ_MTI_BIT] & mtip;

    // MTIP tracks the timer line and ignores CSR writes
    always_ff @(posedge clk) begin
        if (rst)
            mtip <= 1'b0;
        else
            mtip <= irq_timer;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus.raw <= `MSTATUS_RESET;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
        end else if (ret_en) begin
            mstatus.f.mpp  <= 2'b00;
            mstatus.f.mie  <= mstatus.f.mpie;
            mstatus.f.mpie <= 1'b1;
        end else if (trap_en) begin
            mepc           <= trap_pc;
            mcause         <= trap_cause;
            mtval          <= trap_tval;
            mstatus.f.mpp  <= 2'b11;  // traps always enter machine mode
            mstatus.f.mpie <= mstatus.f.mie;
            mstatus.f.mie  <= 1'b0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MSTATUS:  mstatus.raw <= wr_data;
                `CSR_MIE:      mie         <= wr_data;
                `CSR_MTVEC:    mtvec       <= wr_data;
                `CSR_MSCRATCH: mscratch    <= wr_data;
                `CSR_MEPC:     mepc        <= wr_data;
                `CSR_MCAUSE:   mcause      <= wr_data;
                `CSR_MTVAL:    mtval       <= wr_data;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== csr_reg_pkg.sv ====
package csr_reg_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // field layout of mstatus, only the machine-mode trap fields are named
    typedef struct packed {
        logic [50:0] upper;
        logic [1:0]  mpp;           // previous privilege, bits 12:11
        logic [2:0]  mid;
        logic        mpie;          // bit 7
        logic [2:0]  mid2;
        logic        mie;           // bit 3
        logic [2:0]  low;
    } mstatus_fields_t;

    // CSR instructions move mstatus as a whole word, traps touch single fields
    typedef union packed {
        xlen_t           raw;
        mstatus_fields_t f;
    } mstatus_t;

endpackage

// ==== csr_tests.txt ====
# name op addr src zimm pc irq hold kind data redirect target
# all hex except hold (decimal), op f sends nothing and expects the interrupt response
rd_mstatus    2 300 0        00 100  0 0  0 a0001800 0 0
wr_mtvec      1 305 80000000 00 104  0 0  0 0        0 0
rw_mscratch   1 340 12345678 00 108  0 0  0 0        0 0
rs_mscratch   2 340 f0       00 10c  0 0  0 12345678 0 0
rc_mscratch   3 340 ff00     00 110  0 0  0 123456f8 0 0
rwi_mscratch  5 340 0        15 114  0 0  0 123400f8 0 0
rsi_mscratch  6 340 0        0a 118  0 0  0 15       0 0
rci_mscratch  7 340 0        03 11c  0 0  0 1f       0 0
rd_mscratch   2 340 0        00 120  0 0  0 1c       0 0
rsi_mstatus   6 300 0        08 124  0 0  0 a0001800 0 0
bad_csr       2 7c0 0        00 1000 0 0  1 0        1 80000000
rd_mcause     2 342 0        00 1004 0 0  0 2        0 0
rd_mtval      2 343 0        00 1008 0 0  0 7c0      0 0
rd_mepc       2 341 0        00 100c 0 0  0 1000     0 0
wr_mstatus    1 300 a0000008 00 1010 0 0  0 a0001880 0 0
ecall         8 000 0        00 2000 0 0  1 0        1 80000000
rd_mstatus2   2 300 0        00 2004 0 0  0 a0001880 0 0
rd_mcause2    2 342 0        00 2008 0 0  0 b        0 0
mret          9 000 0        00 200c 0 0  2 0        1 2000
rd_mstatus3   2 300 0        00 2010 0 0  0 a0000088 0 0
set_mtie      2 304 80       00 2014 0 0  0 0        0 0
irq_take      f 000 0        00 3000 1 0  3 0        1 80000000
irq_mcause    2 342 0        00 3000 1 0  0 8000000000000007 0 0
irq_mepc      2 341 0        00 3004 1 0  0 3000     0 0
rd_mip_high   2 344 0        00 3008 1 0  0 80       0 0
irq_masked    2 300 0        00 300c 1 0  0 a0001880 0 0
irq_low       2 344 0        00 3010 0 0  0 0        0 0
mret2         9 000 0        00 3014 0 0  2 0        1 3000
rd_mstatus4   2 300 0        00 3018 0 0  0 a0000088 0 0
fc_hold       1 340 aa       00 4000 0 30 0 1c       0 0
fc_1          2 340 100      00 4004 0 0  0 aa       0 0
fc_2          3 340 2        00 4008 0 0  0 1aa      0 0
fc_3          5 340 0        07 400c 0 0  0 1a8      0 0
fc_4          2 340 0        00 4010 0 0  0 7        0 0
fc_5          6 340 0        10 4014 0 0  0 7        0 0
fc_6          2 340 0        00 4018 0 0  0 17       0 0

// ==== csr_unit.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_unit import csr_reg_pkg::*, csr_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_valid,
    input  csr_op_e    cmd_op,
    input  csr_addr_t  cmd_addr,
    input  xlen_t      cmd_src,
    input  logic [4:0] cmd_zimm,
    input  xlen_t      cmd_pc,
    output logic       cmd_credit,
    output logic       rsp_valid,
    output rsp_kind_e  rsp_kind,
    output xlen_t      rsp_data,
    output logic       rsp_redirect,
    output xlen_t      rsp_target,
    input  logic       rsp_credit,
    input  logic       irq_timer
);

    logic       head_valid;
    csr_op_e    head_op;
    csr_addr_t  head_addr;
    xlen_t      head_src;
    logic [4:0] head_zimm;
    xlen_t      head_pc;
    logic       head_pop;
    xlen_t      rd_data;
    logic       rd_err;
    xlen_t      alu_value;
    xlen_t      mtvec;
    xlen_t      mepc;
    logic       irq_pending;
    logic       wr_en;
    xlen_t      wr_data;
    logic       trap_en;
    xlen_t      trap_cause;
    xlen_t      trap_pc;
    xlen_t      trap_tval;
    logic       ret_en;

    csr_cmd_queue #(
        .DEPTH (`CMD_DEPTH)
    ) queue_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_src    (cmd_src),
        .cmd_zimm   (cmd_zimm),
        .cmd_pc     (cmd_pc),
        .head_pop   (head_pop),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_src   (head_src),
        .head_zimm  (head_zimm),
        .head_pc    (head_pc),
        .cmd_credit (cmd_credit)
    );

    trap_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head_op      (head_op),
        .head_addr    (head_addr),
        .head_src     (head_src),
        .head_zimm    (head_zimm),
        .head_pc      (head_pc),
        .head_pop     (head_pop),
        .rd_err       (rd_err),
        .rd_data      (rd_data),
        .alu_value    (alu_value),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .irq_pending  (irq_pending),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .trap_en      (trap_en),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .trap_tval    (trap_tval),
        .ret_en       (ret_en),
        .rsp_credit   (rsp_credit),
        .rsp_valid    (rsp_valid),
        .rsp_kind     (rsp_kind),
        .rsp_data     (rsp_data),
        .rsp_redirect (rsp_redirect),
        .rsp_target   (rsp_target)
    );

    csr_alu alu_i (
        .op        (head_op),
        .old_value (rd_data),
        .src       (head_src),
        .zimm      (head_zimm),
        .new_value (alu_value)
    );

    // the head command's address serves both the read and the write port
    csr_file regs_i (
        .clk         (clk),
        .rst         (rst),
        .rd_addr     (head_addr),
        .rd_data     (rd_data),
        .rd_err      (rd_err),
        .wr_en       (wr_en),
        .wr_addr     (head_addr),
        .wr_data     (wr_data),
        .trap_en     (trap_en),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval),
        .ret_en      (ret_en),
        .irq_timer   (irq_timer),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .irq_pending (irq_pending)
    );

endmodule

// ==== flist.f ====
+incdir+.
csr_reg_pkg.sv
csr_cmd_pkg.sv
csr_cmd_queue.sv
csr_alu.sv
csr_file.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module tb_csr_unit import csr_reg_pkg::*, csr_cmd_pkg::*; ();

    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT = 200;
    localparam logic [3:0] OP_NONE = 4'hf;  // line that only expects an interrupt response

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    csr_op_e    cmd_op;
    csr_addr_t  cmd_addr;
    xlen_t      cmd_src;
    logic [4:0] cmd_zimm;
    xlen_t      cmd_pc;
    logic       cmd_credit;
    logic       rsp_valid;
    rsp_kind_e  rsp_kind;
    xlen_t      rsp_data;
    logic       rsp_redirect;
    xlen_t      rsp_target;
    logic       rsp_credit;
    logic       irq_timer;

    logic [127:0] t_name [MAX_TESTS];
    logic [3:0]   t_op [MAX_TESTS];
    csr_addr_t    t_addr [MAX_TESTS];
    xlen_t        t_src [MAX_TESTS];
    logic [4:0]   t_zimm [MAX_TESTS];
    xlen_t        t_pc [MAX_TESTS];
    logic         t_irq [MAX_TESTS];
    int           t_hold [MAX_TESTS];
    logic [1:0]   t_kind [MAX_TESTS];
    xlen_t        t_data [MAX_TESTS];
    logic         t_redirect [MAX_TESTS];
    xlen_t        t_target [MAX_TESTS];
    int           num_tests;

    rsp_kind_e got_kind [$];
    xlen_t     got_data [$];
    logic      got_redirect [$];
    xlen_t     got_target [$];

    int   sent;
    int   returned;
    int   peak;
    int   mismatches;
    int   timeouts;
    int   other_errors;
    logic abort;

    mstatus_t model_mstatus;
    xlen_t    model_mepc;
    xlen_t    model_mcause;

    csr_unit dut_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_src      (cmd_src),
        .cmd_zimm     (cmd_zimm),
        .cmd_pc       (cmd_pc),
        .cmd_credit   (cmd_credit),
        .rsp_valid    (rsp_valid),
        .rsp_kind     (rsp_kind),
        .rsp_data     (rsp_data),
        .rsp_redirect (rsp_redirect),
        .rsp_target   (rsp_target),
        .rsp_credit   (rsp_credit),
        .irq_timer    (irq_timer)
    );

    always #10 clk = ~clk;

    // responses and returned command credits are captured mid-cycle
    always @(negedge clk) begin
        if (!rst && rsp_valid) begin
            got_kind.push_back(rsp_kind);
            got_data.push_back(rsp_data);
            got_redirect.push_back(rsp_redirect);
            got_target.push_back(rsp_target);
        end
        if (!rst && cmd_credit)
            returned++;
    end

    task automatic check_kind(input string what, input rsp_kind_e exp, input rsp_kind_e act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %0s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_data(input string what, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %0s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %0s: expected %b, actual %b", what, exp, act);
        end
    endtask

    function automatic logic known_csr(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
            `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP: known_csr = 1'b1;
            default: known_csr = 1'b0;
        endcase
    endfunction

    function automatic xlen_t csr_result(input logic [3:0] op, input xlen_t old_value,
                                         input xlen_t src, input logic [4:0] zimm);
        xlen_t operand;
        if (op == OP_CSRRWI || op == OP_CSRRSI || op == OP_CSRRCI)
            operand = {59'b0, zimm};
        else
            operand = src;
        if (op == OP_CSRRW || op == OP_CSRRWI)
            csr_result = operand;
        else if (op == OP_CSRRS || op == OP_CSRRSI)
            csr_result = old_value | operand;
        else
            csr_result = old_value & ~operand;
    endfunction

    task automatic enter_trap(input xlen_t cause, input xlen_t pc);
        model_mepc = pc;
        model_mcause = cause;
        model_mstatus.f.mpp = 2'b11;
        model_mstatus.f.mpie = model_mstatus.f.mie;
        model_mstatus.f.mie = 1'b0;
    endtask

    // second opinion on mstatus, mepc and mcause, kept apart from the expected columns
    task automatic follow_model(input string tag, input int i, input xlen_t data,
                                input xlen_t target);
        if (t_op[i] == OP_NONE) begin
            enter_trap(`CAUSE_MTI, t_pc[i]);
        end else if (t_op[i] == OP_ECALL) begin
            enter_trap(`CAUSE_ECALL_M, t_pc[i]);
        end else if (t_op[i] == OP_MRET) begin
            check_data({tag, " model mepc"}, model_mepc, target);
            model_mstatus.f.mpp = 2'b00;
            model_mstatus.f.mie = model_mstatus.f.mpie;
            model_mstatus.f.mpie = 1'b1;
        end else if (!known_csr(t_addr[i])) begin
            enter_trap(`CAUSE_ILLEGAL, t_pc[i]);
        end else begin
            case (t_addr[i])
                `CSR_MSTATUS: begin
                    check_data({tag, " model mstatus"}, model_mstatus.raw, data);
                    model_mstatus.raw = csr_result(t_op[i], model_mstatus.raw, t_src[i],
                                                   t_zimm[i]);
                end
                `CSR_MEPC: begin
                    check_data({tag, " model mepc"}, model_mepc, data);
                    model_mepc = csr_result(t_op[i], model_mepc, t_src[i], t_zimm[i]);
                end
                `CSR_MCAUSE: begin
                    check_data({tag, " model mcause"}, model_mcause, data);
                    model_mcause = csr_result(t_op[i], model_mcause, t_src[i], t_zimm[i]);
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic load_tests();
        int               fd;
        int               n;
        int               hold;
        logic [127:0]     tok;
        logic [8*200-1:0] rest;
        xlen_t            f_op;
        xlen_t            f_addr;
        xlen_t            f_src;
        xlen_t            f_zimm;
        xlen_t            f_pc;
        xlen_t            f_irq;
        xlen_t            f_kind;
        xlen_t            f_data;
        xlen_t            f_redir;
        xlen_t            f_target;
        num_tests = 0;
        fd = $fopen("csr_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open csr_tests.txt");
            other_errors++;
        end else begin
            while (num_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    n = $fgets(rest, fd);  // column description
                end else begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %d %h %h %h %h", f_op, f_addr, f_src,
                                f_zimm, f_pc, f_irq, hold, f_kind, f_data, f_redir, f_target);
                    if (n != 11) begin
                        $display("test line after %0s is malformed", tok);
                        other_errors++;
                    end else begin
                        t_name[num_tests] = tok;
                        t_op[num_tests] = f_op[3:0];
                        t_addr[num_tests] = f_addr[11:0];
                        t_src[num_tests] = f_src;
                        t_zimm[num_tests] = f_zimm[4:0];
                        t_pc[num_tests] = f_pc;
                        t_irq[num_tests] = f_irq[0];
                        t_hold[num_tests] = hold;
                        t_kind[num_tests] = f_kind[1:0];
                        t_data[num_tests] = f_data;
                        t_redirect[num_tests] = f_redir[0];
                        t_target[num_tests] = f_target;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("csr_tests.txt holds no tests");
                other_errors++;
            end
        end
    endtask

    task automatic wait_queue_empty(output logic ok);
        int n;
        n = 0;
        ok = 1'b1;
        while (ok && returned != sent) begin
            if (n == TIMEOUT) begin
                $display("timeout: command queue did not drain within %0d cycles", TIMEOUT);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(posedge clk);
                #2;
                n++;
            end
        end
    endtask

    task automatic wait_cmd_credit(output logic ok);
        int n;
        n = 0;
        ok = 1'b1;
        while (ok && sent - returned >= `CMD_DEPTH) begin
            if (n == TIMEOUT) begin
                $display("timeout: no command credit came back within %0d cycles", TIMEOUT);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(posedge clk);
                #2;
                n++;
            end
        end
    endtask

    task automatic wait_response(output logic ok);
        int n;
        n = 0;
        ok = 1'b1;
        while (ok && got_kind.size() == 0) begin
            if (n == TIMEOUT) begin
                $display("timeout: no response arrived within %0d cycles", TIMEOUT);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(posedge clk);
                #2;
                n++;
            end
        end
    endtask

    task automatic send_commands();
        logic ok;
        int   i;
        ok = 1'b1;
        for (i = 0; i < num_tests && ok && !abort; i++) begin
            if (t_op[i] != OP_NONE) begin
                if (t_irq[i] != irq_timer)
                    wait_queue_empty(ok);  // the timer line only moves with an idle queue
                if (ok)
                    wait_cmd_credit(ok);
                if (ok) begin
                    cmd_valid = 1'b1;
                    cmd_op = csr_op_e'(t_op[i]);
                    cmd_addr = t_addr[i];
                    cmd_src = t_src[i];
                    cmd_zimm = t_zimm[i];
                    cmd_pc = t_pc[i];
                    irq_timer = t_irq[i];
                    sent++;
                    if (sent - returned > peak)
                        peak = sent - returned;
                    @(posedge clk);
                    #2;
                    cmd_valid = 1'b0;
                end
            end
        end
        if (!ok)
            abort = 1'b1;
    endtask

    task automatic check_responses();
        logic      ok;
        int        i;
        string     tag;
        rsp_kind_e kind;
        xlen_t     data;
        logic      redirect;
        xlen_t     target;
        ok = 1'b1;
        for (i = 0; i < num_tests && ok && !abort; i++) begin
            wait_response(ok);
            if (ok) begin
                kind = got_kind.pop_front();
                data = got_data.pop_front();
                redirect = got_redirect.pop_front();
                target = got_target.pop_front();
                tag = $sformatf("%0s", t_name[i]);
                check_kind({tag, " kind"}, rsp_kind_e'(t_kind[i]), kind);
                check_data({tag, " data"}, t_data[i], data);
                check_flag({tag, " redirect"}, t_redirect[i], redirect);
                check_data({tag, " target"}, t_target[i], target);
                follow_model(tag, i, data, target);
                repeat (t_hold[i]) begin
                    @(posedge clk);
                    #2;
                end
                rsp_credit = 1'b1;
                @(posedge clk);
                #2;
                rsp_credit = 1'b0;
            end
        end
        if (!ok)
            abort = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = OP_CSRRW;
        cmd_addr = '0;
        cmd_src = '0;
        cmd_zimm = '0;
        cmd_pc = '0;
        rsp_credit = 1'b0;
        irq_timer = 1'b0;
        sent = 0;
        returned = 0;
        peak = 0;
        mismatches = 0;
        timeouts = 0;
        other_errors = 0;
        abort = 1'b0;
        model_mstatus.raw = `MSTATUS_RESET;
        model_mepc = '0;
        model_mcause = '0;
        load_tests();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        if (num_tests > 0) begin
            fork
                send_commands();
                check_responses();
            join
        end
        repeat (10) begin
            @(posedge clk);
            #2;
        end
        if (got_kind.size() != 0) begin
            $display("%0d responses arrived that no test expected", got_kind.size());
            other_errors++;
        end
        if (returned != sent) begin
            $display("%0d command credits came back for %0d commands sent", returned, sent);
            other_errors++;
        end
        if (peak != `CMD_DEPTH) begin
            $display("the command queue peaked at %0d entries and never filled", peak);
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== trap_ctrl.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module trap_ctrl import csr_reg_pkg::*, csr_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       head_valid,
    input  csr_op_e    head_op,
    input  csr_addr_t  head_addr,
    input  xlen_t      head_src,
    input  logic [4:0] head_zimm,
    input  xlen_t      head_pc,
    output logic       head_pop,
    input  logic       rd_err,
    input  xlen_t      rd_data,
    input  xlen_t      alu_value,
    input  xlen_t      mtvec,
    input  xlen_t      mepc,
    input  logic       irq_pending,
    output logic       wr_en,
    output xlen_t      wr_data,
    output logic       trap_en,
    output xlen_t      trap_cause,
    output xlen_t      trap_pc,
    output xlen_t      trap_tval,
    output logic       ret_en,
    input  logic       rsp_credit,
    output logic       rsp_valid,
    output rsp_kind_e  rsp_kind,
    output xlen_t      rsp_data,
    output logic       rsp_redirect,
    output xlen_t      rsp_target
);

    localparam int CW = $clog2(`RSP_CREDITS + 1);

    logic [CW-1:0] credits;
    logic      credit_ok;
    logic      take_irq;
    logic      exec;
    logic      fire;
    logic      is_csr;
    logic      zero_operand;
    rsp_kind_e kind_c;
    xlen_t     data_c;
    logic      redirect_c;
    xlen_t     target_c;

    assign credit_ok = (credits != '0);
    assign take_irq  = irq_pending & credit_ok;  // an interrupt wins over the queue head
    assign exec      = head_valid & credit_ok & ~irq_pending;
    assign fire      = take_irq | exec;
    assign is_csr    = ~head_op[3];

    // set and clear with an all-zero operand leave the register untouched
    assign zero_operand = head_op[1] & (head_op[2] ? (head_zimm == 5'd0) : (head_src == '0));

    always_comb begin
        head_pop   = 1'b0;
        wr_en      = 1'b0;
        wr_data    = alu_value;
        trap_en    = 1'b0;
        trap_cause = '0;
        trap_pc    = head_pc;
        trap_tval  = '0;
        ret_en     = 1'b0;
        kind_c     = RSP_DONE;
        data_c     = '0;
        redirect_c = 1'b0;
        target_c   = '0;
        if (take_irq) begin
            trap_en    = 1'b1;
            trap_cause = `CAUSE_MTI;
            trap_pc    = head_valid ? head_pc : '0;
            kind_c     = RSP_IRQ;
            redirect_c = 1'b1;
            target_c   = mtvec;
        end else if (exec) begin
            head_pop = 1'b1;
            if (is_csr && rd_err) begin
                trap_en    = 1'b1;
                trap_cause = `CAUSE_ILLEGAL;
                trap_tval  = xlen_t'(head_addr);
                kind_c     = RSP_TRAP;
                redirect_c = 1'b1;
                target_c   = mtvec;
            end else if (is_csr) begin
                wr_en  = ~zero_operand;
                data_c = rd_data;
            end else if (head_op == OP_ECALL) begin
                trap_en    = 1'b1;
                trap_cause = `CAUSE_ECALL_M;
                kind_c     = RSP_TRAP;
                redirect_c = 1'b1;
                target_c   = mtvec;
            end else begin
                ret_en     = 1'b1;
                kind_c     = RSP_RET;
                redirect_c = 1'b1;
                target_c   = mepc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits      <= CW'(`RSP_CREDITS);
            rsp_valid    <= 1'b0;
            rsp_redirect <= 1'b0;
        end else begin
            credits      <= credits - CW'(fire) + CW'(rsp_credit);
            rsp_valid    <= fire;
            rsp_redirect <= fire & redirect_c;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rsp_kind   <= kind_c;
            rsp_data   <= data_c;
            rsp_target <= target_c;
        end
    end

endmodule
